/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_board_top
RTL_TOP   ?= board_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
src/board_pkg.sv
src/reset_ctrl.sv
src/input_sync.sv
src/pio_regs.sv
src/panel_drive.sv
src/board_top.sv
tb/tb_board_top.sv

/* src/board_pkg.sv */
package board_pkg;

    // ========================================
    // board dimensions and timing
    // ========================================
    localparam int NUM_SW   = 18;
    localparam int NUM_KEY  = 4;     // active low push buttons
    localparam int NUM_HEX  = 8;
    localparam int NUM_LEDG = 9;
    localparam int NUM_LEDR = 18;
    localparam int DATA_W   = 32;    // soc export word
    localparam int ADDR_W   = 2;

    localparam int DEBOUNCE_CYCLES = 16;
    localparam int DEBOUNCE_CNT_W  = $clog2(DEBOUNCE_CYCLES + 1);
    localparam int RST_SYNC_STAGES = 3;

    typedef logic [DEBOUNCE_CNT_W-1:0] debounce_cnt_t;
    localparam debounce_cnt_t DEBOUNCE_MAX = debounce_cnt_t'(DEBOUNCE_CYCLES);

    // ========================================
    // register map
    // ========================================
    typedef logic [ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t REG_LED  = 2'd0;
    localparam reg_addr_t REG_SW   = 2'd1;   // read only
    localparam reg_addr_t REG_EDGE = 2'd2;
    localparam reg_addr_t REG_MASK = 2'd3;

    // ========================================
    // payload and bus types
    // ========================================
    typedef logic [NUM_SW-1:0]  sw_t;
    typedef logic [NUM_KEY-1:0] key_t;
    typedef logic [6:0]         seg_t;   // gfedcba, low = lit

    typedef struct packed {
        reg_addr_t         addr;
        logic              wr;
        logic              rd;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        seg_t [NUM_HEX-1:0] hex;    // digit 7 in the top slot
        logic [NUM_LEDR-1:0] ledr;
        logic [NUM_LEDG-1:0] ledg;
    } panel_t;

    // hex 0..F on a common anode digit
    localparam seg_t SEG7_TABLE [0:15] = '{
        7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
        7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
        7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
        7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
    };

endpackage

/* src/board_top.sv */
`timescale 1ns/1ps

// board i/o subsystem, reset, input conditioning, registers, panel
module board_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                pll_locked,
    input  board_pkg::key_t     key,
    input  board_pkg::sw_t      sw,
    input  logic                sensor_int,
    input  board_pkg::bus_req_t bus_req,
    output board_pkg::bus_rsp_t bus_rsp,
    output logic                irq,
    output board_pkg::panel_t   panel
);

    import board_pkg::*;

    logic              sys_rst_n;
    sw_t               sw_clean;
    key_t              key_clean;
    logic [DATA_W-1:0] led_export;

    // ========================================
    // reset
    // ========================================
    reset_ctrl i_reset_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .pll_locked (pll_locked),
        .key0       (key[0]),     // raw button, not debounced
        .sys_rst_n  (sys_rst_n)
    );

    // ========================================
    // input conditioning
    // ========================================
    input_sync #(
        .payload_t   (sw_t),
        .RESET_VALUE (sw_t'('0))
    ) i_sw_sync (
        .clk   (clk),
        .rst_n (sys_rst_n),
        .raw   (sw),
        .clean (sw_clean)
    );

    input_sync #(
        .payload_t   (key_t),
        .RESET_VALUE (key_t'('1))   // buttons idle high
    ) i_key_sync (
        .clk   (clk),
        .rst_n (sys_rst_n),
        .raw   (key),
        .clean (key_clean)
    );

    // ========================================
    // registers and panel
    // ========================================
    pio_regs i_pio_regs (
        .clk        (clk),
        .rst_n      (sys_rst_n),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .sw_clean   (sw_clean),
        .key_clean  (key_clean),
        .sensor_int (sensor_int),   // already in the clk domain
        .led_export (led_export),
        .irq        (irq)
    );

    panel_drive i_panel_drive (
        .clk        (clk),
        .rst_n      (sys_rst_n),
        .led_export (led_export),
        .panel      (panel)
    );

endmodule

/* src/input_sync.sv */
`timescale 1ns/1ps

// synchronizer and debouncer for a vector of board inputs
module input_sync #(
    parameter type      payload_t   = board_pkg::sw_t,
    parameter payload_t RESET_VALUE = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t raw,
    output payload_t clean
);

    import board_pkg::*;

    payload_t      meta_q;
    payload_t      sync_q;
    payload_t      last_q;    // last sampled synchronized value
    debounce_cnt_t cnt_q;

    // ========================================
    // two flop synchronizer
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            meta_q <= RESET_VALUE;
            sync_q <= RESET_VALUE;
        end else begin
            meta_q <= raw;
            sync_q <= meta_q;
        end
    end

    // ========================================
    // debounce
    // ========================================
    // counter sits saturated while the input is quiet
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q <= RESET_VALUE;
            cnt_q  <= DEBOUNCE_MAX;
            clean  <= RESET_VALUE;
        end else if (sync_q != last_q) begin
            last_q <= sync_q;   // restart on any bit change
            cnt_q  <= '0;
        end else if (cnt_q != DEBOUNCE_MAX) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == DEBOUNCE_MAX - 1'b1) begin
                clean <= last_q;   // stable long enough
            end
        end
    end

endmodule

/* src/panel_drive.sv */
`timescale 1ns/1ps

// front panel, led slices and eight seven segment digits
module panel_drive (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [board_pkg::DATA_W-1:0] led_export,
    output board_pkg::panel_t            panel
);

    import board_pkg::*;

    panel_t panel_d;

    // ========================================
    // decode
    // ========================================
    always_comb begin
        // one nibble per digit, digit 0 from the low nibble
        for (int i = 0; i < NUM_HEX; i++) begin
            panel_d.hex[i] = SEG7_TABLE[led_export[4*i +: 4]];
        end

        // {ledr, ledg} is the low end of the export word
        panel_d.ledg = led_export[NUM_LEDG-1:0];
        panel_d.ledr = led_export[NUM_LEDG +: NUM_LEDR];
    end

    // ========================================
    // output register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            panel.hex  <= {NUM_HEX{SEG7_TABLE[0]}};   // all digits read 0
            panel.ledr <= '0;
            panel.ledg <= '0;
        end else begin
            panel <= panel_d;
        end
    end

endmodule

/* src/pio_regs.sv */
`timescale 1ns/1ps

// led / switch / key edge register block on a strobe bus
module pio_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  board_pkg::bus_req_t          bus_req,
    output board_pkg::bus_rsp_t          bus_rsp,
    input  board_pkg::sw_t               sw_clean,
    input  board_pkg::key_t              key_clean,
    input  logic                         sensor_int,
    output logic [board_pkg::DATA_W-1:0] led_export,
    output logic                         irq
);

    import board_pkg::*;

    logic              wr_led;
    logic              wr_edge;
    logic              wr_mask;
    logic              rd_fire;
    key_t              key_prev_q;
    key_t              press;
    key_t              edge_clr;
    key_t              edge_q;
    key_t              mask_q;
    logic [DATA_W-1:0] rd_data;
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;

    // ========================================
    // decode
    // ========================================
    // writes to REG_SW have no decode and fall away
    assign wr_led  = bus_req.wr && (bus_req.addr == REG_LED);
    assign wr_edge = bus_req.wr && (bus_req.addr == REG_EDGE);
    assign wr_mask = bus_req.wr && (bus_req.addr == REG_MASK);
    assign rd_fire = bus_req.rd && !bus_req.wr;   // write wins a collision

    // press is a high to low step of the debounced key
    assign press    = key_prev_q & ~key_clean;
    assign edge_clr = wr_edge ? bus_req.wdata[NUM_KEY-1:0] : '0;

    // ========================================
    // registers
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_export <= '0;
            mask_q     <= '0;
            edge_q     <= '0;
            key_prev_q <= '1;   // released
            irq        <= 1'b0;
        end else begin
            if (wr_led) begin
                led_export <= bus_req.wdata;
            end
            if (wr_mask) begin
                mask_q <= bus_req.wdata[NUM_KEY-1:0];
            end
            key_prev_q <= key_clean;
            edge_q     <= (edge_q & ~edge_clr) | press;   // set beats clear
            irq        <= |(edge_q & mask_q);
        end
    end

    // ========================================
    // read path
    // ========================================
    always_comb begin
        rd_data = '0;
        case (bus_req.addr)
            REG_LED:  rd_data = led_export;
            REG_SW:   rd_data = {sensor_int, {(DATA_W-1-NUM_SW){1'b0}}, sw_clean};
            REG_EDGE: rd_data[NUM_KEY-1:0] = edge_q;
            REG_MASK: rd_data[NUM_KEY-1:0] = mask_q;
            default:  rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_fire;   // one cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_q <= rd_data;
        end
    end

    assign bus_rsp.rvalid = rvalid_q;
    assign bus_rsp.rdata  = rdata_q;

endmodule

/* src/reset_ctrl.sv */
`timescale 1ns/1ps

// system reset from board reset, pll lock and key 0
module reset_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic pll_locked,
    input  logic key0,
    output logic sys_rst_n
);

    import board_pkg::*;

    logic                       src_ok;
    logic [RST_SYNC_STAGES-1:0] stage_q;

    // any source low pulls reset at once
    assign src_ok = rst_n & pll_locked & key0;

    // ========================================
    // release synchronizer
    // ========================================
    // ones shift in from the bottom, the top stage is the reset
    always_ff @(posedge clk or negedge src_ok) begin
        if (!src_ok) begin
            stage_q <= '0;
        end else begin
            stage_q <= {stage_q[RST_SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign sys_rst_n = stage_q[RST_SYNC_STAGES-1];   // clean rising edge

endmodule

/* tb/tb_board_top.sv */
`timescale 1ns/1ps

module tb_board_top;

    import board_pkg::*;

    typedef enum int {
        OP_SET,      // drive switches, keys, sensor, then hold
        OP_WRITE,
        OP_READ,     // polls while cycles is nonzero
        OP_PANEL,
        OP_IRQ,
        OP_RESET     // addr picks the source
    } op_e;

    typedef struct {
        op_e         op;
        reg_addr_t   addr;
        logic [31:0] data;
        logic [31:0] expected;
        int          cycles;
        string       name;
    } step_t;

    logic     clk;
    logic     rst_n;
    logic     pll_locked;
    key_t     key;
    sw_t      sw;
    logic     sensor_int;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;
    logic     irq;
    panel_t   panel;

    step_t       steps[$];
    logic [15:0] lfsr_q    = 16'd58064;
    int          cycle_cnt = 0;
    int          n_checks  = 0;
    int          n_errors  = 0;
    logic        timed_out = 1'b0;

    board_top i_board_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .pll_locked (pll_locked),
        .key        (key),
        .sw         (sw),
        .sensor_int (sensor_int),
        .bus_req    (bus_req),
        .bus_rsp    (bus_rsp),
        .irq        (irq),
        .panel      (panel)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // ========================================
    // helpers
    // ========================================
    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic out;
        out    = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ 16'hB400;
        end
        return out;
    endfunction

    function automatic logic [31:0] lfsr_word(input int bits);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < bits; i++) begin
            w = {w[30:0], lfsr_bit()};
        end
        return w;
    endfunction

    // digit i from nibble i, ledg low 9 bits, ledr the next 18
    function automatic panel_t expected_panel(input logic [31:0] word);
        panel_t p;
        for (int i = 0; i < NUM_HEX; i++) begin
            p.hex[i] = SEG7_TABLE[word[4*i +: 4]];
        end
        p.ledg = word[8:0];
        p.ledr = word[26:9];
        return p;
    endfunction

    function automatic logic [31:0] pack_inputs(input sw_t s, input key_t k, input logic sense);
        return {9'd0, sense, k, s};
    endfunction

    task automatic add_step(input op_e op, input reg_addr_t addr, input logic [31:0] data,
                            input logic [31:0] expected, input int cycles, input string name);
        step_t s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.expected = expected;
        s.cycles   = cycles;
        s.name     = name;
        steps.push_back(s);
    endtask

    task automatic apply_inputs(input step_t s);
        @(posedge clk);
        sw         <= s.data[NUM_SW-1:0];
        key        <= s.data[NUM_SW +: NUM_KEY];
        sensor_int <= s.data[NUM_SW+NUM_KEY];
        repeat (s.cycles) @(posedge clk);
    endtask

    task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
        @(posedge clk);
        bus_req.addr  <= addr;
        bus_req.wdata <= data;
        bus_req.wr    <= 1'b1;
        bus_req.rd    <= 1'b0;
        @(posedge clk);
        bus_req.wr <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, input string name,
                            output logic [31:0] data, output logic ok);
        int lat;
        lat  = 0;
        ok   = 1'b0;
        data = '0;
        @(posedge clk);
        bus_req.addr <= addr;
        bus_req.rd   <= 1'b1;
        bus_req.wr   <= 1'b0;
        @(posedge clk);
        bus_req.rd <= 1'b0;
        while (!ok && lat < 4) begin
            @(negedge clk);
            lat++;
            if (bus_rsp.rvalid) ok = 1'b1;
            else @(posedge clk);
        end
        if (!ok) begin
            $display("no read response for %s within 4 cycles", name);
            n_errors++;
            timed_out = 1'b1;
        end else begin
            data = bus_rsp.rdata;
            n_checks++;
            if (lat != 1) begin
                $display("error %s latency: expected 1, actual %0d", name, lat);
                n_errors++;
            end
            @(negedge clk);
            if (bus_rsp.rvalid) begin
                $display("rvalid stayed high for more than one cycle in %s", name);
                n_errors++;
            end
        end
    endtask

    task automatic compare_read(input step_t s);
        logic [31:0] data;
        logic        ok;
        int          t0;
        t0 = cycle_cnt;
        read_reg(s.addr, s.name, data, ok);
        while (ok && data !== s.expected && cycle_cnt - t0 < s.cycles) begin
            read_reg(s.addr, s.name, data, ok);
        end
        if (ok) begin
            n_checks++;
            if (data !== s.expected) begin
                $display("error %s: expected %h, actual %h", s.name, s.expected, data);
                n_errors++;
            end
        end
    endtask

    // panel is two edges behind the write strobe
    task automatic check_panel(input step_t s);
        panel_t exp;
        exp = expected_panel(s.data);
        @(posedge clk);
        @(negedge clk);
        n_checks++;
        if (panel !== exp) begin
            $display("error %s: expected %h, actual %h", s.name, exp, panel);
            n_errors++;
        end
    endtask

    task automatic watch_irq(input step_t s);
        int waited;
        waited = 0;
        @(negedge clk);
        while (irq !== s.expected[0] && waited < s.cycles) begin
            @(negedge clk);
            waited++;
        end
        n_checks++;
        if (irq !== s.expected[0]) begin
            $display("error %s: expected %b, actual %b", s.name, s.expected[0], irq);
            n_errors++;
        end
    endtask

    task automatic pulse_reset(input step_t s);
        @(posedge clk);
        case (s.addr)
            2'd0:    rst_n <= 1'b0;
            2'd1:    pll_locked <= 1'b0;
            default: key[0] <= 1'b0;
        endcase
        repeat (s.cycles) @(posedge clk);
        rst_n      <= 1'b1;
        pll_locked <= 1'b1;
        key[0]     <= 1'b1;
        repeat (RST_SYNC_STAGES + 2) @(posedge clk);   // release stages
    endtask

    task automatic run_step(input step_t s);
        case (s.op)
            OP_SET:   apply_inputs(s);
            OP_WRITE: write_reg(s.addr, s.data);
            OP_READ:  compare_read(s);
            OP_PANEL: check_panel(s);
            OP_IRQ:   watch_irq(s);
            default:  pulse_reset(s);
        endcase
    endtask

    // ========================================
    // stimulus table
    // ========================================
    task automatic build_table();
        logic [31:0] led_a;
        logic [31:0] led_b;
        logic [31:0] junk;
        logic [31:0] led_c;
        logic [31:0] led_d;
        logic [31:0] sw_word;
        logic [31:0] key3_down;
        logic [31:0] keys_up;
        sw_t         sw_pat;
        int          settle;
        led_a     = lfsr_word(32);
        led_b     = lfsr_word(32);
        junk      = lfsr_word(32);
        led_c     = lfsr_word(32) | 32'h1;   // must be nonzero
        led_d     = lfsr_word(32) | 32'h1;
        sw_pat    = sw_t'(lfsr_word(NUM_SW));
        sw_word   = {1'b1, {(31-NUM_SW){1'b0}}, sw_pat};
        key3_down = pack_inputs(sw_pat, 4'b0111, 1'b0);
        keys_up   = pack_inputs(sw_pat, '1, 1'b0);
        settle    = 4 * DEBOUNCE_CYCLES;

        add_step(OP_PANEL, REG_LED, 32'h0, 32'h0, 0, "reset_panel");
        add_step(OP_IRQ, REG_LED, 32'h0, 32'h0, 0, "reset_irq");
        add_step(OP_READ, REG_LED, 32'h0, 32'h0, 0, "reset_led");
        add_step(OP_READ, REG_EDGE, 32'h0, 32'h0, 0, "reset_edge");
        add_step(OP_READ, REG_MASK, 32'h0, 32'h0, 0, "reset_mask");

        add_step(OP_WRITE, REG_LED, led_a, 32'h0, 0, "led_a_write");
        add_step(OP_PANEL, REG_LED, led_a, 32'h0, 0, "led_a_panel");
        add_step(OP_READ, REG_LED, 32'h0, led_a, 0, "led_a_read");
        add_step(OP_WRITE, REG_LED, led_b, 32'h0, 0, "led_b_write");
        add_step(OP_PANEL, REG_LED, led_b, 32'h0, 0, "led_b_panel");
        add_step(OP_READ, REG_LED, 32'h0, led_b, 0, "led_b_read");
        add_step(OP_READ, REG_SW, 32'h0, 32'h0, 0, "sw_before_write");
        add_step(OP_WRITE, REG_SW, junk, 32'h0, 0, "sw_write");
        add_step(OP_READ, REG_SW, 32'h0, 32'h0, 0, "sw_after_write");
        add_step(OP_READ, REG_LED, 32'h0, led_b, 0, "led_after_sw_write");

        // switches, then a glitch to the inverse pattern
        add_step(OP_SET, REG_LED, pack_inputs(sw_pat, '1, 1'b1), 32'h0, 0, "sw_set");
        add_step(OP_READ, REG_SW, 32'h0, sw_word, settle, "sw_read");
        add_step(OP_SET, REG_LED, pack_inputs(~sw_pat, '1, 1'b1), 32'h0,
                 DEBOUNCE_CYCLES/2 - 1, "sw_glitch");   // next set adds one edge
        add_step(OP_SET, REG_LED, pack_inputs(sw_pat, '1, 1'b1), 32'h0, 0, "sw_restore");
        // about 30 cycles of reads across the window where the glitch could leak
        for (int k = 0; k < 10; k++) begin
            add_step(OP_READ, REG_SW, 32'h0, sw_word, 0, "sw_glitch_filtered");
        end

        // key 2 press, mask, clear
        add_step(OP_SET, REG_LED, pack_inputs(sw_pat, 4'b1011, 1'b1), 32'h0, 0, "key2_press");
        add_step(OP_READ, REG_EDGE, 32'h0, 32'h4, settle, "edge_set");
        add_step(OP_IRQ, REG_LED, 32'h0, 32'h0, 0, "irq_masked");
        add_step(OP_WRITE, REG_MASK, 32'h4, 32'h0, 0, "mask_write");
        add_step(OP_IRQ, REG_LED, 32'h0, 32'h1, 3, "irq_raised");
        add_step(OP_READ, REG_MASK, 32'h0, 32'h4, 0, "mask_read");
        add_step(OP_WRITE, REG_EDGE, 32'h4, 32'h0, 0, "edge_clear");
        add_step(OP_IRQ, REG_LED, 32'h0, 32'h0, 3, "irq_cleared");
        add_step(OP_READ, REG_EDGE, 32'h0, 32'h0, 0, "edge_cleared");
        add_step(OP_SET, REG_LED, pack_inputs(sw_pat, '1, 1'b0), 32'h0, settle, "key2_release");
        add_step(OP_READ, REG_EDGE, 32'h0, 32'h0, 0, "edge_after_release");

        // pll lock loss and then key 0 with a key 3 edge pending
        add_step(OP_WRITE, REG_LED, led_c, 32'h0, 0, "pll_led_write");
        add_step(OP_WRITE, REG_MASK, 32'hF, 32'h0, 0, "pll_mask_write");
        add_step(OP_SET, REG_LED, key3_down, 32'h0, settle, "pll_key3_press");
        add_step(OP_SET, REG_LED, keys_up, 32'h0, settle, "pll_key3_release");
        add_step(OP_READ, REG_EDGE, 32'h0, 32'h8, 0, "pll_edge_before");
        add_step(OP_IRQ, REG_LED, 32'h0, 32'h1, 0, "pll_irq_before");
        add_step(OP_READ, REG_LED, 32'h0, led_c, 0, "pll_led_before");
        add_step(OP_RESET, 2'd1, 32'h0, 32'h0, 5, "pll_drop");
        add_step(OP_PANEL, REG_LED, 32'h0, 32'h0, 0, "pll_panel");
        add_step(OP_READ, REG_LED, 32'h0, 32'h0, 0, "pll_led");
        add_step(OP_READ, REG_MASK, 32'h0, 32'h0, 0, "pll_mask");
        add_step(OP_READ, REG_EDGE, 32'h0, 32'h0, 0, "pll_edge");
        add_step(OP_IRQ, REG_LED, 32'h0, 32'h0, 0, "pll_irq");
        add_step(OP_WRITE, REG_LED, led_d, 32'h0, 0, "key0_led_write");
        add_step(OP_WRITE, REG_MASK, 32'hF, 32'h0, 0, "key0_mask_write");
        add_step(OP_SET, REG_LED, key3_down, 32'h0, settle, "key0_key3_press");
        add_step(OP_SET, REG_LED, keys_up, 32'h0, settle, "key0_key3_release");
        add_step(OP_READ, REG_EDGE, 32'h0, 32'h8, 0, "key0_edge_before");
        add_step(OP_IRQ, REG_LED, 32'h0, 32'h1, 0, "key0_irq_before");
        add_step(OP_READ, REG_LED, 32'h0, led_d, 0, "key0_led_before");
        add_step(OP_RESET, 2'd2, 32'h0, 32'h0, 5, "key0_press");
        add_step(OP_PANEL, REG_LED, 32'h0, 32'h0, 0, "key0_panel");
        add_step(OP_READ, REG_LED, 32'h0, 32'h0, 0, "key0_led");
        add_step(OP_READ, REG_MASK, 32'h0, 32'h0, 0, "key0_mask");
        add_step(OP_READ, REG_EDGE, 32'h0, 32'h0, 0, "key0_edge");
        add_step(OP_IRQ, REG_LED, 32'h0, 32'h0, 0, "key0_irq");
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        rst_n      = 1'b0;
        pll_locked = 1'b1;
        key        = '1;   // released
        sw         = '0;
        sensor_int = 1'b0;
        bus_req    = '0;
        build_table();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (RST_SYNC_STAGES + 2) @(posedge clk);
        for (int i = 0; i < steps.size() && !timed_out; i++) begin
            run_step(steps[i]);
        end
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
